/* source/riscette_consts.svh */
/* core-wide constants; function codes above FN_LAST_SUPPORTED halt the core
   (mul, div and floating point are not built) */
`ifndef RISCETTE_CONSTS_SVH
`define RISCETTE_CONSTS_SVH

`define RESET_PC          24'h000000  // first fetch address
`define NUM_REGS          16
`define REG_AW            4           // register index width

// alu function codes
`define FN_MOV            4'h0
`define FN_LSL            4'h1
`define FN_ASR            4'h2
`define FN_ROR            4'h3
`define FN_AND            4'h4
`define FN_ANDN           4'h5
`define FN_IOR            4'h6
`define FN_XOR            4'h7
`define FN_ADD            4'h8
`define FN_SUB            4'h9
`define FN_LAST_SUPPORTED 4'h9

`endif

/* source/riscette_pkg.sv */
/* shared types of the core; instruction layouts follow the RISC5 field
   positions, format 2 reuses the immediate layout with a 16-bit offset */
`include "riscette_consts.svh"

package riscette_pkg;

  // ------------------------------------------------
  // instruction views
  // ------------------------------------------------
  typedef struct packed {
    logic [1:0]         pq;      // format
    logic               u;
    logic               v;
    logic [`REG_AW-1:0] a;       // destination / store source
    logic [`REG_AW-1:0] b;       // first operand
    logic [3:0]         op;      // alu function
    logic [11:0]        unused;
    logic [`REG_AW-1:0] c;       // second operand register
  } fmt_reg_t;

  typedef struct packed {
    logic [1:0]         pq;
    logic               u;
    logic               v;
    logic [`REG_AW-1:0] a;
    logic [`REG_AW-1:0] b;
    logic [3:0]         op;
    logic [15:0]        imm16;   // immediate or memory offset
  } fmt_imm_t;

  // low half is either register c or the immediate
  typedef union packed {
    fmt_reg_t r;
    fmt_imm_t i;
  } instr_u;

  // ------------------------------------------------
  // decoded control and bus request
  // ------------------------------------------------
  typedef struct packed {
    logic [1:0]         fmt;
    logic [`REG_AW-1:0] rd;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [3:0]         fn;
    logic [31:0]        imm;       // already extended
    logic               is_store;
    logic               illegal;   // sends the core to HALT
  } dec_t;

  typedef struct packed {
    logic        stb;
    logic        we;
    logic [23:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  typedef enum logic [2:0] {
    RESET, FETCH, DECODE, EXEC, ACCESS, WB, HALT
  } state_e;

endpackage

/* source/instr_decode.sv */
/* instruction register and field decoder; byte access (v=1 in format 2),
   format 3 and function codes above 9 are flagged illegal */
`include "riscette_consts.svh"

module instr_decode (
  input  logic               clk,
  input  logic               rst,
  input  logic               ir_we,
  input  logic [31:0]        bus_rdata,
  output riscette_pkg::dec_t dec
);

  riscette_pkg::instr_u ir;

  always_ff @(posedge clk) begin
    if (rst) begin
      ir <= '0;                       // decodes as a legal mov
    end else if (ir_we) begin
      ir <= bus_rdata;
    end
  end

  // ------------------------------------------------
  // field extraction
  // ------------------------------------------------
  always_comb begin
    dec.fmt      = ir.r.pq;
    dec.rd       = ir.r.a;
    dec.rs1      = ir.r.b;
    dec.rs2      = ir.r.c;            // register view of the low half
    dec.fn       = ir.r.op;
    dec.is_store = (ir.i.pq == 2'd2) && ir.i.u;

    // immediate view of the same low half
    case (ir.i.pq)
      2'd1:    dec.imm = {{16{ir.i.v}}, ir.i.imm16};         // ones or zeros fill
      2'd2:    dec.imm = {{16{ir.i.imm16[15]}}, ir.i.imm16}; // signed offset
      default: dec.imm = 32'h0;
    endcase

    dec.illegal = (ir.i.op > `FN_LAST_SUPPORTED) ||
                  (ir.i.pq == 2'd3) ||                  // branches
                  ((ir.i.pq == 2'd2) && ir.i.v);        // byte access
  end

endmodule

/* source/alu_execute.sv */
/* single-cycle alu for functions 0..9; shifts use op2[4:0], format 2
   always adds to form the word address */
`include "riscette_consts.svh"

module alu_execute (
  input  logic               clk,
  input  logic               alu_run,
  input  riscette_pkg::dec_t dec,
  input  logic [31:0]        rs1_data,
  input  logic [31:0]        rs2_data,
  output logic [31:0]        result
);

  logic [31:0] op1;
  logic [31:0] op2;
  logic [3:0]  fn;
  logic [4:0]  sh;
  logic [63:0] rot;
  logic [31:0] res;

  assign op1 = rs1_data;
  assign op2 = (dec.fmt == 2'd0) ? rs2_data : dec.imm;
  assign fn  = (dec.fmt == 2'd2) ? `FN_ADD : dec.fn;  // address calc
  assign sh  = op2[4:0];
  assign rot = {op1, op1} >> sh;

  // ------------------------------------------------
  // function select
  // ------------------------------------------------
  always_comb begin
    case (fn)
      `FN_MOV:  res = op2;
      `FN_LSL:  res = op1 << sh;
      `FN_ASR:  res = $signed(op1) >>> sh;
      `FN_ROR:  res = rot[31:0];
      `FN_AND:  res = op1 & op2;
      `FN_ANDN: res = op1 & ~op2;
      `FN_IOR:  res = op1 | op2;
      `FN_XOR:  res = op1 ^ op2;
      `FN_ADD:  res = op1 + op2;
      `FN_SUB:  res = op1 - op2;
      default:  res = 32'h0;          // never run, decoder halts first
    endcase
  end

  always_ff @(posedge clk) begin
    if (alu_run) begin
      result <= res;
    end
  end

  // illegal codes must have been caught in DECODE
  a_fn_supported: assert property (
    @(posedge clk) alu_run |-> (dec.fn <= `FN_LAST_SUPPORTED)
  );

endmodule

/* source/reg_result.sv */
/* 16 x 32 register file, cleared on reset; R0 is an ordinary register.
   load data is sampled every cycle, so WB must follow the ack directly */
`include "riscette_consts.svh"

module reg_result (
  input  logic               clk,
  input  logic               rst,
  input  logic               rf_rd,
  input  logic               rf_we,
  input  logic               wb_sel,
  input  riscette_pkg::dec_t dec,
  input  logic [31:0]        alu_result,
  input  logic [31:0]        bus_rdata,
  output logic [31:0]        rs1_data,
  output logic [31:0]        rs2_data,
  output logic [31:0]        store_data
);

  logic [31:0]        regs [`NUM_REGS];
  logic [`REG_AW-1:0] rd2_addr;
  logic [31:0]        rd2_q;
  logic [31:0]        load_q;
  logic [31:0]        wb_data;

  // second port reads rd for memory ops
  assign rd2_addr = (dec.fmt == 2'd2) ? dec.rd : dec.rs2;
  assign wb_data  = wb_sel ? load_q : alu_result;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= 32'h0;
      end
    end else if (rf_we) begin
      regs[dec.rd] <= wb_data;
    end
  end

  always_ff @(posedge clk) begin
    load_q <= bus_rdata;              // holds the word of the ack cycle
    if (rf_rd) begin
      rs1_data <= regs[dec.rs1];
      rd2_q    <= regs[rd2_addr];
    end
  end

  assign rs2_data   = rd2_q;
  assign store_data = rd2_q;

endmodule

/* source/core_ctrl.sv */
/* multicycle sequencer: fetch, decode, execute, access, write-back.
   bus request is held stable from strobe to ack; HALT is left only by reset */
`include "riscette_consts.svh"

module core_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   bus_ack,
  input  riscette_pkg::dec_t     dec,
  input  logic [31:0]            alu_result,
  input  logic [31:0]            store_data,
  output riscette_pkg::bus_req_t bus,
  output logic                   ir_we,
  output logic                   rf_rd,
  output logic                   alu_run,
  output logic                   rf_we,
  output logic                   wb_sel,
  output logic                   halted
);

  riscette_pkg::state_e state;
  riscette_pkg::state_e state_nx;
  logic [23:0]          pc;

  // ------------------------------------------------
  // state and program counter
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= riscette_pkg::RESET;
      pc    <= `RESET_PC;
    end else begin
      state <= state_nx;
      if (ir_we) begin
        pc <= pc + 24'd4;             // advance on fetch ack
      end
    end
  end

  // ------------------------------------------------
  // next state and outputs
  // ------------------------------------------------
  always_comb begin
    state_nx = state;
    bus      = '0;
    ir_we    = 1'b0;
    rf_rd    = 1'b0;
    alu_run  = 1'b0;
    rf_we    = 1'b0;
    wb_sel   = 1'b0;
    halted   = 1'b0;
    case (state)
      riscette_pkg::RESET: begin
        state_nx = riscette_pkg::FETCH;
      end
      riscette_pkg::FETCH: begin
        bus.stb  = 1'b1;
        bus.addr = pc;
        ir_we    = bus_ack;
        if (bus_ack) state_nx = riscette_pkg::DECODE;
      end
      riscette_pkg::DECODE: begin
        rf_rd    = 1'b1;              // operands read this cycle
        state_nx = dec.illegal ? riscette_pkg::HALT : riscette_pkg::EXEC;
      end
      riscette_pkg::EXEC: begin
        alu_run  = 1'b1;
        state_nx = (dec.fmt == 2'd2) ? riscette_pkg::ACCESS : riscette_pkg::WB;
      end
      riscette_pkg::ACCESS: begin
        bus.stb   = 1'b1;
        bus.we    = dec.is_store;
        bus.addr  = alu_result[23:0];
        bus.wdata = store_data;
        if (bus_ack) begin
          state_nx = dec.is_store ? riscette_pkg::FETCH : riscette_pkg::WB;
        end
      end
      riscette_pkg::WB: begin
        rf_we    = 1'b1;
        wb_sel   = (dec.fmt == 2'd2); // load result
        state_nx = riscette_pkg::FETCH;
      end
      riscette_pkg::HALT: begin
        halted = 1'b1;
      end
      default: state_nx = riscette_pkg::RESET;
    endcase
  end

  // request must not move while the slave has not answered
  a_bus_stable: assert property (
    @(posedge clk) disable iff (rst)
    (bus.stb && !bus_ack) |=> $stable(bus)
  );

  // halt keeps the illegal instruction and never writes the register file
  a_halt_quiet: assert property (
    @(posedge clk) disable iff (rst)
    (state == riscette_pkg::HALT) |-> dec.illegal && !rf_we
  );

endmodule

/* source/riscette_core.sv */
/* core top: strobe/acknowledge bus with a 24-bit address and 32-bit data,
   word access only */
module riscette_core (
  input  logic                   clk,
  input  logic                   rst,
  output riscette_pkg::bus_req_t bus,
  input  logic [31:0]            bus_rdata,
  input  logic                   bus_ack,
  output logic                   halted
);

  riscette_pkg::dec_t dec;
  logic [31:0]        rs1_data;
  logic [31:0]        rs2_data;
  logic [31:0]        store_data;
  logic [31:0]        alu_result;
  logic               ir_we;
  logic               rf_rd;
  logic               alu_run;
  logic               rf_we;
  logic               wb_sel;

  instr_decode u_instr_decode (
    .clk       (clk),
    .rst       (rst),
    .ir_we     (ir_we),
    .bus_rdata (bus_rdata),
    .dec       (dec)
  );

  alu_execute u_alu_execute (
    .clk      (clk),
    .alu_run  (alu_run),
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (alu_result)
  );

  reg_result u_reg_result (
    .clk        (clk),
    .rst        (rst),
    .rf_rd      (rf_rd),
    .rf_we      (rf_we),
    .wb_sel     (wb_sel),
    .dec        (dec),
    .alu_result (alu_result),
    .bus_rdata  (bus_rdata),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .store_data (store_data)
  );

  core_ctrl u_core_ctrl (
    .clk        (clk),
    .rst        (rst),
    .bus_ack    (bus_ack),
    .dec        (dec),
    .alu_result (alu_result),
    .store_data (store_data),
    .bus        (bus),
    .ir_we      (ir_we),
    .rf_rd      (rf_rd),
    .alu_run    (alu_run),
    .rf_we      (rf_we),
    .wb_sel     (wb_sel),
    .halted     (halted)
  );

endmodule

/* testbench/store_checker.sv */
/* expected stores come from a model run of the image at reset release, so
   the image must be complete before rst falls; data words live at 0x100 up */
module store_checker #(
  parameter int MEM_WORDS = 128
) (
  input  logic                   clk,
  input  logic                   rst,
  input  riscette_pkg::bus_req_t bus,
  input  logic                   bus_ack,
  input  logic                   halted,
  input  logic [31:0]            image [MEM_WORDS],
  output int                     errors,
  output int                     stores_seen,
  output int                     stores_expected,
  output logic                   done
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [23:0] DATA_BASE    = 24'h000100;
  localparam int          QUIET_CYCLES = 20;   // bus must stay idle after halt

  logic [23:0] exp_addr [$];
  logic [31:0] exp_data [$];
  string       exp_name [$];
  logic [23:0] next_fetch = 24'h0;
  logic        ref_ready  = 1'b0;
  logic        done_q     = 1'b0;
  int          err_cnt    = 0;
  int          seen       = 0;
  int          exp_count  = 0;
  int          quiet      = 0;

  assign errors          = err_cnt;
  assign stores_seen     = seen;
  assign stores_expected = exp_count;
  assign done            = done_q;

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic logic [31:0] alu_ref(input logic [3:0] fn, input logic [31:0] x,
                                          input logic [31:0] y);
    logic [4:0] s;
    s = y[4:0];                               // shifts see 5 bits only
    case (fn)
      4'd0:    return y;
      4'd1:    return x << s;
      4'd2:    return $unsigned($signed(x) >>> s);
      4'd3:    return (x >> s) | (x << (6'd32 - {1'b0, s}));
      4'd4:    return x & y;
      4'd5:    return x & ~y;
      4'd6:    return x | y;
      4'd7:    return x ^ y;
      4'd8:    return x + y;
      4'd9:    return x - y;
      default: return 32'h0;
    endcase
  endfunction

  function automatic void run_reference();
    logic [31:0] r [16];
    logic [31:0] m [MEM_WORDS];
    logic [31:0] ins;
    logic [31:0] op2;
    logic [31:0] ea;
    logic [6:0]  pc;
    string       last;
    r    = '{default: 32'h0};
    m    = image;
    pc   = 7'd0;
    last = "none";
    for (int step = 0; step < MEM_WORDS; step++) begin
      ins = m[pc];
      pc  = pc + 7'd1;
      if (ins[31:30] == 2'd3 || ins[19:16] > 4'd9 || (ins[31:30] == 2'd2 && ins[28])) begin
        break;                                // core halts here
      end
      if (ins[31:30] == 2'd2) begin
        ea = r[ins[23:20]] + {{16{ins[15]}}, ins[15:0]};
        if (ins[29]) begin
          exp_addr.push_back(ea[23:0]);
          exp_data.push_back(r[ins[27:24]]);
          exp_name.push_back(last);
          m[ea[8:2]] = r[ins[27:24]];
        end else begin
          r[ins[27:24]] = m[ea[8:2]];
          last = "load back";
        end
      end else begin
        op2 = (ins[31:30] == 2'd0) ? r[ins[3:0]] : {{16{ins[28]}}, ins[15:0]};
        r[ins[27:24]] = alu_ref(ins[19:16], r[ins[23:20]], op2);
        last = $sformatf("fmt%0d fn%0d", ins[31:30], ins[19:16]);
      end
    end
  endfunction

  // --------------------------------------------------
  // bus monitor
  // --------------------------------------------------
  always @(posedge clk) begin
    if (!rst) begin
      if (!ref_ready) begin
        run_reference();
        exp_count = exp_addr.size();
        ref_ready = 1'b1;
        if (halted) begin
          $display("halted is high right after reset");
          err_cnt++;
        end
      end
      if (bus.stb && bus_ack && !bus.we && bus.addr < DATA_BASE) begin
        if (bus.addr !== next_fetch) begin
          $display("** Error [fetch order] expected %h actual %h", next_fetch, bus.addr);
          err_cnt++;
        end
        next_fetch = bus.addr + 24'd4;        // resync after a miss
      end
      if (bus.stb && bus_ack && bus.we) begin
        if (seen >= exp_count) begin
          $display("unexpected store of %h to %h", bus.wdata, bus.addr);
          err_cnt++;
        end else begin
          if (bus.addr !== exp_addr[seen]) begin
            $display("** Error [%s addr] expected %h actual %h", exp_name[seen],
                     exp_addr[seen], bus.addr);
            err_cnt++;
          end
          if (bus.wdata !== exp_data[seen]) begin
            $display("** Error [%s] expected %h actual %h", exp_name[seen],
                     exp_data[seen], bus.wdata);
            err_cnt++;
          end
        end
        seen++;
      end
      if (halted) begin
        if (bus.stb) begin
          $display("strobe to %h seen after halt", bus.addr);
          err_cnt++;
        end
        quiet++;
        if (quiet == QUIET_CYCLES) begin
          if (seen < exp_count) begin
            $display("%0d of %0d stores missing at halt", exp_count - seen, exp_count);
            err_cnt++;
          end
          done_q <= 1'b1;
        end
      end
    end
  end

endmodule

/* testbench/tb_riscette.sv */
/* one 128-word memory holds program and data (data from 0x100); ack comes
   0 to 3 cycles after the strobe rises, from a fixed seed */
module tb_riscette;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS    = 128;
  localparam int RESET_CYCLES = 10;
  localparam int CLK_PERIOD   = 4;

  logic                   clk       = 1'b0;
  logic                   rst;
  logic [31:0]            bus_rdata = 32'h0;
  logic                   bus_ack   = 1'b0;
  logic                   halted;
  riscette_pkg::bus_req_t bus;
  logic [31:0]            mem [MEM_WORDS];
  logic [6:0]             n;
  int                     prog_len  = 0;
  int                     wait_cnt  = -1;
  integer                 seed      = 27;
  int                     errors;
  int                     stores_seen;
  int                     stores_expected;
  logic                   done;

  always #2 clk = ~clk;

  riscette_core u_riscette_core (
    .clk       (clk),
    .rst       (rst),
    .bus       (bus),
    .bus_rdata (bus_rdata),
    .bus_ack   (bus_ack),
    .halted    (halted)
  );

  store_checker #(.MEM_WORDS(MEM_WORDS)) u_checker (
    .clk             (clk),
    .rst             (rst),
    .bus             (bus),
    .bus_ack         (bus_ack),
    .halted          (halted),
    .image           (mem),
    .errors          (errors),
    .stores_seen     (stores_seen),
    .stores_expected (stores_expected),
    .done            (done)
  );

  // --------------------------------------------------
  // instruction encoding
  // --------------------------------------------------
  function automatic logic [31:0] reg_op(input logic [3:0] fn, input logic [3:0] rd,
                                         input logic [3:0] rs1, input logic [3:0] rs2);
    return {2'd0, 2'b00, rd, rs1, fn, 12'h0, rs2};
  endfunction

  function automatic logic [31:0] imm_op(input logic [3:0] fn, input logic [3:0] rd,
                                         input logic [3:0] rs1, input logic v,
                                         input logic [15:0] imm);
    return {2'd1, 1'b0, v, rd, rs1, fn, imm};
  endfunction

  function automatic logic [31:0] mem_op(input logic store, input logic [3:0] ra,
                                         input logic [3:0] rb, input logic [15:0] off);
    return {2'd2, store, 1'b0, ra, rb, 4'h0, off};
  endfunction

  task automatic add_instr(input logic [31:0] word);
    mem[n] = word;
    n      = n + 7'd1;
  endtask

  // memory model, answers after a random wait
  always @(posedge clk) begin
    #0.5;
    if (rst) begin
      bus_ack  = 1'b0;
      wait_cnt = -1;
    end else if (bus_ack) begin
      bus_ack = 1'b0;                         // one-cycle ack
    end else if (bus.stb) begin
      if (wait_cnt < 0) begin
        wait_cnt = $unsigned($random(seed)) % 4;
      end
      if (wait_cnt == 0) begin
        bus_ack = 1'b1;
        if (bus.we) begin
          mem[bus.addr[8:2]] = bus.wdata;
        end else begin
          bus_rdata = mem[bus.addr[8:2]];
        end
      end
      wait_cnt = wait_cnt - 1;
    end
  end

  // --------------------------------------------------
  // program image and reset
  // --------------------------------------------------
  initial begin : stimulus
    rst = 1'b1;
    n   = 7'd0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'hDA00_0000 | (i * 32'h0000_0101);
    end
    add_instr(imm_op(4'd0, 4'd2, 4'd0, 1'b1, 16'h8765));  // ones fill
    add_instr(imm_op(4'd0, 4'd3, 4'd0, 1'b0, 16'h0025));  // shift 37, low bits 5
    add_instr(imm_op(4'd0, 4'd7, 4'd0, 1'b0, 16'h0100));  // store base
    add_instr(imm_op(4'd0, 4'd8, 4'd0, 1'b0, 16'h0200));
    for (int f = 0; f < 10; f++) begin
      add_instr(reg_op(f[3:0], 4'd5, 4'd2, 4'd3));
      add_instr(mem_op(1'b1, 4'd5, 4'd7, 16'(4 * f)));
    end
    for (int f = 0; f < 10; f++) begin
      add_instr(imm_op(f[3:0], 4'd5, 4'd2, f[0], {4'hA, f[3:0], 8'h23}));
      add_instr(mem_op(1'b1, 4'd5, 4'd7, 16'(40 + 4 * f)));
    end
    add_instr(mem_op(1'b0, 4'd6, 4'd7, 16'h0008));        // round trip via R6
    add_instr(mem_op(1'b1, 4'd6, 4'd8, 16'hFFFC));        // negative offset
    add_instr(reg_op(4'hA, 4'd9, 4'd2, 4'd3));            // mul, not built
    prog_len = int'(n);
    repeat (RESET_CYCLES) @(posedge clk);
    #0.5;
    rst = 1'b0;
  end

  initial begin : finish_run
    wait (done === 1'b1);
    $display("errors %0d, stores %0d of %0d", errors, stores_seen, stores_expected);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (prog_len > 0);
    #(RESET_CYCLES * CLK_PERIOD + prog_len * 12 * CLK_PERIOD);
    if (!halted) begin
      $display("halted did not rise within the time of %0d instructions", prog_len);
    end else begin
      $display("bus did not settle after halt");
    end
    $display("errors %0d, stores %0d of %0d", errors, stores_seen, stores_expected);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* riscette.f */
+incdir+source
source/riscette_pkg.sv
source/instr_decode.sv
source/alu_execute.sv
source/reg_result.sv
source/core_ctrl.sv
source/riscette_core.sv
testbench/store_checker.sv
testbench/tb_riscette.sv

/* Makefile */
# Verilator flow for the riscette core
TOP = tb_riscette

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module riscette_core -f riscette.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f riscette.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
